// ==== project.f ====
common/lc4_pkg.sv
common/insn_stream_if.sv
fetch/lc4_fetch.sv
rtl/insn_queue.sv
execute/lc4_regfile.sv
execute/lc4_execute.sv
rtl/lc4_core_top.sv
sim/lc4_core_props.sv
sim/tb_lc4_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LC4 core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
   -f project.f --top-module tb_lc4_core -o tb_lc4_core
status=0
output=$(./obj_dir/tb_lc4_core 2>&1) || status=$?
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'ALL CHECKS PASSED'; then
   exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1

// ==== sim/tb_lc4_core.sv ====
`timescale 1ns/100ps

module tb_lc4_core;
   import lc4_pkg::*;

   localparam int RESET_CYCLES = 10;

   // one expected retire record
   typedef struct packed {
      word_t    pc;
      word_t    insn;
      logic     we;
      reg_sel_t rd;
      word_t    data;
      logic     nzp_we;
      nzp_t     nzp;
   } retire_t;

   logic     gwe;
   logic     i_rst;
   logic     o_imem_cyc;
   logic     o_imem_stb;
   word_t    o_imem_adr;
   word_t    i_imem_dat;
   logic     i_imem_ack;
   logic     o_wb_valid;
   word_t    o_wb_pc;
   word_t    o_wb_insn;
   logic     o_wb_we;
   reg_sel_t o_wb_rd;
   word_t    o_wb_data;
   logic     o_wb_nzp_we;
   nzp_t     o_wb_nzp;

   word_t    imem [65536];
   retire_t  exp_q [$];
   integer   seed = 32'had87_a160;
   int       wait_left;
   int       retired;
   logic     bus_busy;
   logic     first_adr_seen;

   lc4_core_top #(
      .QUEUE_DEPTH (4)
   ) lc4_core_top_i (
      .gwe         (gwe),
      .i_rst       (i_rst),
      .o_imem_cyc  (o_imem_cyc),
      .o_imem_stb  (o_imem_stb),
      .o_imem_adr  (o_imem_adr),
      .i_imem_dat  (i_imem_dat),
      .i_imem_ack  (i_imem_ack),
      .o_wb_valid  (o_wb_valid),
      .o_wb_pc     (o_wb_pc),
      .o_wb_insn   (o_wb_insn),
      .o_wb_we     (o_wb_we),
      .o_wb_rd     (o_wb_rd),
      .o_wb_data   (o_wb_data),
      .o_wb_nzp_we (o_wb_nzp_we),
      .o_wb_nzp    (o_wb_nzp)
   );

   always #2 gwe = ~gwe;

   task automatic stop_with_failure();
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first failed check");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_reg(input string name, input reg_sel_t got, input reg_sel_t exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_nzp(input string name, input nzp_t got, input nzp_t exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
         stop_with_failure();
      end
   endtask

   // places the instruction in memory and queues its retire record
   task automatic add_row(input word_t pc, input word_t insn, input logic we,
                          input reg_sel_t rd, input word_t data, input logic nzp_we,
                          input nzp_t nzp);
      retire_t row;
      imem[pc] = insn;
      row = '{pc, insn, we, rd, data, nzp_we, nzp};
      exp_q.push_back(row);
   endtask

   task automatic load_tables();
      word_t adr;
      // unused words hold opcode 1111 and a pattern of the whole address
      for (int a = 0; a < 65536; a++) begin
         adr = a[15:0];
         imem[a] = {4'hf, adr[15:4] ^ adr[11:0]};
      end
      // columns are pc insn we rd data nzp_we nzp
      add_row(16'h8200, 16'h0802, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h8201, 16'h93fb, 1'b1, 3'd1, 16'hfffb, 1'b1, 3'b100);
      add_row(16'h8202, 16'h0605, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h8203, 16'h94f3, 1'b1, 3'd2, 16'h00f3, 1'b1, 3'b001);
      add_row(16'h8204, 16'h0c03, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h8205, 16'hd5a5, 1'b1, 3'd2, 16'ha5f3, 1'b1, 3'b100);
      add_row(16'h8206, 16'h1642, 1'b1, 3'd3, 16'ha5ee, 1'b1, 3'b100);
      add_row(16'h8207, 16'h1891, 1'b1, 3'd4, 16'ha5f8, 1'b1, 3'b100);
      add_row(16'h8208, 16'h1a65, 1'b1, 3'd5, 16'h0000, 1'b1, 3'b010);
      add_row(16'h8209, 16'h0a04, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h820a, 16'h5c83, 1'b1, 3'd6, 16'ha5e2, 1'b1, 3'b100);
      add_row(16'h820b, 16'h5e52, 1'b1, 3'd7, 16'hfffb, 1'b1, 3'b100);
      add_row(16'h820c, 16'h5c9b, 1'b1, 3'd6, 16'h001d, 1'b1, 3'b001);
      add_row(16'h820d, 16'h587c, 1'b1, 3'd4, 16'hfff8, 1'b1, 3'b100);
      add_row(16'h820e, 16'h0803, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h8212, 16'h11bd, 1'b1, 3'd0, 16'h001a, 1'b1, 3'b001);
      add_row(16'h8213, 16'h0206, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h821a, 16'h9600, 1'b1, 3'd3, 16'h0000, 1'b1, 3'b010);
      add_row(16'h821b, 16'h05fc, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h8218, 16'h1240, 1'b1, 3'd1, 16'h0015, 1'b1, 3'b001);
      add_row(16'h8219, 16'h0fff, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h8219, 16'h0fff, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      add_row(16'h8219, 16'h0fff, 1'b0, 3'd0, 16'h0000, 1'b0, 3'b000);
      // shadow of the taken branch at 820e, would clobber r0
      imem[16'h820f] = 16'h9001;
      imem[16'h8210] = 16'h9002;
      imem[16'h8211] = 16'h9003;
   endtask

   task automatic check_retire(input retire_t e);
      check_word("o_wb_pc", o_wb_pc, e.pc);
      check_word("o_wb_insn", o_wb_insn, e.insn);
      check_bit("o_wb_we", o_wb_we, e.we);
      check_bit("o_wb_nzp_we", o_wb_nzp_we, e.nzp_we);
      if (e.we) begin
         check_reg("o_wb_rd", o_wb_rd, e.rd);
         check_word("o_wb_data", o_wb_data, e.data);
      end
      if (e.nzp_we) begin
         check_nzp("o_wb_nzp", o_wb_nzp, e.nzp);
      end
   endtask

   // wishbone slave with 0 to 3 wait cycles per read
   always @(posedge gwe) begin
      #0.5;
      if (i_imem_ack) begin
         // the acked cycle ends at this edge
         check_bit("o_imem_cyc", o_imem_cyc, 1'b0);
         check_bit("o_imem_stb", o_imem_stb, 1'b0);
         i_imem_ack = 1'b0;
         bus_busy = 1'b0;
      end else if (o_imem_stb) begin
         check_bit("o_imem_cyc", o_imem_cyc, 1'b1);
         if (!bus_busy) begin
            bus_busy = 1'b1;
            wait_left = $random(seed) & 3;
            if (!first_adr_seen) begin
               check_word("o_imem_adr", o_imem_adr, 16'h8200);
               first_adr_seen = 1'b1;
            end
         end
         if (wait_left == 0) begin
            i_imem_dat = imem[o_imem_adr];
            i_imem_ack = 1'b1;
         end else begin
            wait_left--;
         end
      end
   end

   initial begin
      gwe = 1'b0;
      i_rst = 1'b1;
      i_imem_ack = 1'b0;
      i_imem_dat = '0;
      bus_busy = 1'b0;
      first_adr_seen = 1'b0;
      retired = 0;
      load_tables();
      repeat (RESET_CYCLES) begin
         @(posedge gwe);
         #0.5;
         check_bit("o_wb_valid", o_wb_valid, 1'b0);
         check_bit("o_imem_cyc", o_imem_cyc, 1'b0);
         check_bit("o_imem_stb", o_imem_stb, 1'b0);
      end
      i_rst = 1'b0;
      @(posedge gwe);
      #0.5;
      check_bit("o_wb_valid", o_wb_valid, 1'b0);
      while (retired < exp_q.size()) begin
         @(negedge gwe);
         if (o_wb_valid) begin
            check_retire(exp_q[retired]);
            retired++;
         end
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

   // watchdog scaled by the length of the retire table
   initial begin
      int limit;
      @(negedge i_rst);
      limit = exp_q.size() * 8 + 50;
      repeat (limit) @(posedge gwe);
      $display("timeout after %0d cycles with %0d of %0d instructions retired",
               limit, retired, exp_q.size());
      stop_with_failure();
   end

endmodule

// ==== sim/lc4_core_props.sv ====
`timescale 1ns/100ps

module lc4_core_props (
   input logic           gwe,
   input logic           i_rst,
   input logic           i_imem_cyc,
   input logic           i_imem_stb,
   input lc4_pkg::word_t i_imem_adr,
   input logic           i_imem_ack,
   input logic           i_wb_valid
);

   // a strobe only ever appears inside a bus cycle
   stb_needs_cyc: assert property (
      @(posedge gwe) disable iff (i_rst) i_imem_stb |-> i_imem_cyc
   ) else $error("wishbone stb high without cyc");

   // address held until the slave acks
   adr_held: assert property (
      @(posedge gwe) disable iff (i_rst)
      (i_imem_stb && !i_imem_ack) |=> $stable(i_imem_adr)
   ) else $error("wishbone adr changed before ack");

   // nothing retires in the first cycle out of reset
   quiet_after_reset: assert property (
      @(posedge gwe) $fell(i_rst) |=> !i_wb_valid
   ) else $error("o_wb_valid high in the cycle after reset");

endmodule

bind lc4_core_top lc4_core_props lc4_core_props_i (
   .gwe        (gwe),
   .i_rst      (i_rst),
   .i_imem_cyc (o_imem_cyc),
   .i_imem_stb (o_imem_stb),
   .i_imem_adr (o_imem_adr),
   .i_imem_ack (i_imem_ack),
   .i_wb_valid (o_wb_valid)
);

// ==== rtl/lc4_core_top.sv ====
`timescale 1ns/100ps

module lc4_core_top #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic              gwe,
   input  logic              i_rst,
   output logic              o_imem_cyc,
   output logic              o_imem_stb,
   output lc4_pkg::word_t    o_imem_adr,
   input  lc4_pkg::word_t    i_imem_dat,
   input  logic              i_imem_ack,
   output logic              o_wb_valid,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output logic              o_wb_we,
   output lc4_pkg::reg_sel_t o_wb_rd,
   output lc4_pkg::word_t    o_wb_data,
   output logic              o_wb_nzp_we,
   output lc4_pkg::nzp_t     o_wb_nzp
);
   import lc4_pkg::*;

   logic  redirect_valid;
   word_t redirect_pc;

   // fetch to queue, queue to execute
   insn_stream_if s_fetch ();
   insn_stream_if s_issue ();

   lc4_fetch lc4_fetch_i (
      .gwe              (gwe),
      .i_rst            (i_rst),
      .o_imem_cyc       (o_imem_cyc),
      .o_imem_stb       (o_imem_stb),
      .o_imem_adr       (o_imem_adr),
      .i_imem_dat       (i_imem_dat),
      .i_imem_ack       (i_imem_ack),
      .i_redirect_valid (redirect_valid),
      .i_redirect_pc    (redirect_pc),
      .s_fetch          (s_fetch.src)
   );

   // a taken branch empties everything younger than itself
   insn_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) insn_queue_i (
      .gwe     (gwe),
      .i_rst   (i_rst),
      .i_flush (redirect_valid),
      .s_in    (s_fetch.dst),
      .s_out   (s_issue.src)
   );

   lc4_execute lc4_execute_i (
      .gwe              (gwe),
      .i_rst            (i_rst),
      .s_issue          (s_issue.dst),
      .o_redirect_valid (redirect_valid),
      .o_redirect_pc    (redirect_pc),
      .o_wb_valid       (o_wb_valid),
      .o_wb_pc          (o_wb_pc),
      .o_wb_insn        (o_wb_insn),
      .o_wb_we          (o_wb_we),
      .o_wb_rd          (o_wb_rd),
      .o_wb_data        (o_wb_data),
      .o_wb_nzp_we      (o_wb_nzp_we),
      .o_wb_nzp         (o_wb_nzp)
   );

endmodule

// ==== execute/lc4_execute.sv ====
`timescale 1ns/100ps

module lc4_execute (
   input  logic              gwe,
   input  logic              i_rst,
   insn_stream_if.dst        s_issue,
   output logic              o_redirect_valid,
   output lc4_pkg::word_t    o_redirect_pc,
   output logic              o_wb_valid,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output logic              o_wb_we,
   output lc4_pkg::reg_sel_t o_wb_rd,
   output lc4_pkg::word_t    o_wb_data,
   output logic              o_wb_nzp_we,
   output lc4_pkg::nzp_t     o_wb_nzp
);
   import lc4_pkg::*;

   word_t    insn;
   word_t    pc;
   opcode_t  opcode;
   reg_sel_t rd_sel;
   reg_sel_t rs_sel;
   word_t    rs_data;
   word_t    rt_data;
   word_t    imm5;
   word_t    imm9;
   word_t    operand;
   word_t    result;
   word_t    br_target;
   logic     reg_we;
   logic     is_br;
   logic     taken;
   logic     fire;
   nzp_t     nzp_q;
   nzp_t     nzp_new;

   // one instruction per cycle, never stalls
   assign s_issue.ready = 1'b1;
   assign fire          = s_issue.valid && s_issue.ready;

   assign insn   = s_issue.pkt.insn;
   assign pc     = s_issue.pkt.pc;
   assign opcode = opcode_t'(insn[15:12]);
   assign rd_sel = insn[11:9];
   // hiconst reads its own destination to keep the low byte
   assign rs_sel = (opcode == OP_HICONST) ? rd_sel : insn[8:6];

   assign imm5    = {{11{insn[4]}}, insn[4:0]};
   assign imm9    = {{7{insn[8]}}, insn[8:0]};
   assign operand = insn[5] ? imm5 : rt_data;

   lc4_regfile lc4_regfile_i (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_rs_sel  (rs_sel),
      .i_rt_sel  (insn[2:0]),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_we      (fire && reg_we),
      .i_rd_sel  (rd_sel),
      .i_rd_data (result)
   );

   // anything not listed retires as a no-op
   always_comb begin
      result = '0;
      reg_we = 1'b0;
      is_br  = 1'b0;
      case (opcode)
         OP_BR: is_br = 1'b1;
         OP_ARITH: begin
            casez (insn[5:3])
               3'b1??, 3'b000: begin
                  result = rs_data + operand;
                  reg_we = 1'b1;
               end
               3'b010: begin
                  result = rs_data - operand;
                  reg_we = 1'b1;
               end
               default: ;
            endcase
         end
         OP_LOGIC: begin
            casez (insn[5:3])
               3'b1??, 3'b000: begin
                  result = rs_data & operand;
                  reg_we = 1'b1;
               end
               3'b010: begin
                  result = rs_data | operand;
                  reg_we = 1'b1;
               end
               3'b011: begin
                  result = rs_data ^ operand;
                  reg_we = 1'b1;
               end
               default: ;
            endcase
         end
         OP_CONST: begin
            result = imm9;
            reg_we = 1'b1;
         end
         OP_HICONST: begin
            result = {insn[7:0], rs_data[7:0]};
            reg_we = 1'b1;
         end
         default: ;
      endcase
   end

   // condition code of the written value
   assign nzp_new[2] = result[15];
   assign nzp_new[1] = (result == '0);
   assign nzp_new[0] = !result[15] && (result != '0);

   assign br_target = pc + 16'd1 + imm9;
   assign taken     = is_br && |(insn[11:9] & nzp_q);

   assign o_redirect_valid = fire && taken;
   assign o_redirect_pc    = br_target;

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         nzp_q      <= NZP_RESET;
         o_wb_valid <= 1'b0;
      end else begin
         o_wb_valid <= fire;
         if (fire && reg_we) begin
            nzp_q <= nzp_new;
         end
      end
   end

   // retire record, qualified by o_wb_valid
   always_ff @(posedge gwe) begin
      if (fire) begin
         o_wb_pc     <= pc;
         o_wb_insn   <= insn;
         o_wb_we     <= reg_we;
         o_wb_rd     <= reg_we ? rd_sel : '0;
         o_wb_data   <= result;
         o_wb_nzp_we <= reg_we;
         o_wb_nzp    <= reg_we ? nzp_new : '0;
      end
   end

endmodule

// ==== execute/lc4_regfile.sv ====
`timescale 1ns/100ps

module lc4_regfile (
   input  logic              gwe,
   input  logic              i_rst,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data,
   input  logic              i_we,
   input  lc4_pkg::reg_sel_t i_rd_sel,
   input  lc4_pkg::word_t    i_rd_data
);
   import lc4_pkg::*;

   localparam int NUM_REGS = 8;

   word_t regs_q [NUM_REGS];

   // reads see the old value, a write lands at the edge
   assign o_rs_data = regs_q[i_rs_sel];
   assign o_rt_data = regs_q[i_rt_sel];

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (i_we) begin
         regs_q[i_rd_sel] <= i_rd_data;
      end
   end

endmodule

// ==== rtl/insn_queue.sv ====
`timescale 1ns/100ps

module insn_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic       gwe,
   input  logic       i_rst,
   input  logic       i_flush,
   insn_stream_if.dst s_in,
   insn_stream_if.src s_out
);
   import lc4_pkg::*;

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam logic [PTR_W:0] FULL_COUNT = QUEUE_DEPTH[PTR_W:0];

   fetch_pkt_t       mem_q [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;
   logic             push;
   logic             pop;

   assign s_in.ready  = (count_q != FULL_COUNT);
   assign s_out.valid = (count_q != '0);
   assign s_out.pkt   = mem_q[rd_ptr_q];

   assign push = s_in.valid && s_in.ready;
   assign pop  = s_out.valid && s_out.ready;

   // flush also drops a push in the same cycle
   always_ff @(posedge gwe) begin
      if (i_rst || i_flush) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // pointers wrap by themselves, depth is a power of two
   always_ff @(posedge gwe) begin
      if (push) begin
         mem_q[wr_ptr_q] <= s_in.pkt;
      end
   end

endmodule

// ==== fetch/lc4_fetch.sv ====
`timescale 1ns/100ps

module lc4_fetch (
   input  logic           gwe,
   input  logic           i_rst,
   output logic           o_imem_cyc,
   output logic           o_imem_stb,
   output lc4_pkg::word_t o_imem_adr,
   input  lc4_pkg::word_t i_imem_dat,
   input  logic           i_imem_ack,
   input  logic           i_redirect_valid,
   input  lc4_pkg::word_t i_redirect_pc,
   insn_stream_if.src     s_fetch
);
   import lc4_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_BUS,
      S_HOLD
   } state_t;

   state_t state_q;
   // address of the instruction on the bus or held, next fetch when idle
   word_t  pc_q;
   word_t  adr_q;
   word_t  insn_q;
   logic   discard_q;
   word_t  start_pc;
   word_t  hold_next_pc;
   logic   push;
   logic   leave_hold;

   assign push       = s_fetch.valid && s_fetch.ready;
   assign start_pc   = i_redirect_valid ? i_redirect_pc : pc_q;
   assign hold_next_pc = i_redirect_valid ? i_redirect_pc : pc_q + 16'd1;
   // a held packet is dropped by redirect, or leaves by transfer
   assign leave_hold = (state_q == S_HOLD) && (i_redirect_valid || push);

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         state_q   <= S_IDLE;
         pc_q      <= RESET_PC;
         discard_q <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               state_q <= S_BUS;
               pc_q    <= start_pc;
            end
            S_BUS: begin
               if (i_redirect_valid) begin
                  pc_q <= i_redirect_pc;
               end
               if (i_imem_ack) begin
                  discard_q <= 1'b0;
                  // stale response, refetch from the new pc
                  if (discard_q || i_redirect_valid) begin
                     state_q <= S_IDLE;
                  end else begin
                     state_q <= S_HOLD;
                  end
               end else if (i_redirect_valid) begin
                  discard_q <= 1'b1;
               end
            end
            S_HOLD: begin
               if (leave_hold) begin
                  state_q <= S_BUS;
                  pc_q    <= hold_next_pc;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // bus address is latched when a cycle starts and stays put until ack
   always_ff @(posedge gwe) begin
      if (state_q == S_IDLE) begin
         adr_q <= start_pc;
      end else if (leave_hold) begin
         adr_q <= hold_next_pc;
      end
      if (state_q == S_BUS && i_imem_ack) begin
         insn_q <= i_imem_dat;
      end
   end

   assign o_imem_cyc = (state_q == S_BUS);
   assign o_imem_stb = (state_q == S_BUS);
   assign o_imem_adr = adr_q;

   assign s_fetch.valid = (state_q == S_HOLD);
   assign s_fetch.pkt   = '{pc: pc_q, insn: insn_q};

endmodule

// ==== common/insn_stream_if.sv ====
`timescale 1ns/100ps

// valid/ready stream of fetched instructions
interface insn_stream_if;
   import lc4_pkg::*;

   logic       valid;
   logic       ready;
   fetch_pkt_t pkt;

   // source holds valid and pkt until the transfer edge
   modport src (
      output valid,
      output pkt,
      input  ready
   );

   modport dst (
      input  valid,
      input  pkt,
      output ready
   );

endinterface

// ==== common/lc4_pkg.sv ====
package lc4_pkg;

   // machine word, used for pc, instruction and register data
   typedef logic [15:0] word_t;

   typedef logic [2:0] reg_sel_t;

   // bit 2 is n, bit 1 is z, bit 0 is p
   typedef logic [2:0] nzp_t;

   // only the opcodes this core executes
   typedef enum logic [3:0] {
      OP_BR      = 4'b0000,
      OP_ARITH   = 4'b0001,
      OP_LOGIC   = 4'b0101,
      OP_CONST   = 4'b1001,
      OP_HICONST = 4'b1101
   } opcode_t;

   // one fetched instruction with its address
   typedef struct packed {
      word_t pc;
      word_t insn;
   } fetch_pkt_t;

   localparam word_t RESET_PC = 16'h8200;

   // z is set out of reset
   localparam nzp_t NZP_RESET = 3'b010;

endpackage
